/* src/aes_pkg.sv */
// AES-128 shared definitions
// Block and word types, register map indices, core states, S-box lookups
// and key schedule round constants
`default_nettype none

package aes_pkg;

	typedef logic [127:0] aes_block_t;	// Word 0 in the top 32 bits
	typedef logic [31:0] aes_word_t;
	typedef logic [3:0] avl_addr_t;
	typedef aes_block_t [0:10] round_key_array_t;

	typedef enum logic [2:0] {
		s_idle,
		s_expand,
		s_first_key,
		s_rounds,
		s_write_back
	} core_state_t;

	// Register map
	localparam avl_addr_t reg_key0 = 4'd0;
	localparam avl_addr_t reg_msg_en0 = 4'd4;
	localparam avl_addr_t reg_msg_de0 = 4'd8;
	localparam avl_addr_t reg_unused0 = 4'd12;	// 12 and 13 read zero
	localparam avl_addr_t reg_start = 4'd14;
	localparam avl_addr_t reg_done = 4'd15;

	localparam logic [0:255][7:0] sbox_table = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	localparam logic [0:255][7:0] inv_sbox_table = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	function automatic logic [7:0] sbox(input logic [7:0] b);
		return sbox_table[b];
	endfunction

	function automatic logic [7:0] inv_sbox(input logic [7:0] b);
		return inv_sbox_table[b];
	endfunction

	// Round constant for key schedule step 1..10
	function automatic logic [7:0] rcon(input logic [3:0] round);
		logic [7:0] rc;
		case (round)
			4'd1: rc = 8'h01;
			4'd2: rc = 8'h02;
			4'd3: rc = 8'h04;
			4'd4: rc = 8'h08;
			4'd5: rc = 8'h10;
			4'd6: rc = 8'h20;
			4'd7: rc = 8'h40;
			4'd8: rc = 8'h80;
			4'd9: rc = 8'h1b;
			4'd10: rc = 8'h36;
			default: rc = 8'h00;
		endcase
		return rc;
	endfunction

endpackage

`default_nettype wire

/* src/aes_ctrl_if.sv */
// Control link between the Avalon register block and the decryption core
// Key and ciphertext go down with a start pulse, plaintext comes back with done
`timescale 1ns/1ps
`default_nettype none

interface aes_ctrl_if
	import aes_pkg::*;
();

	aes_block_t key;
	aes_block_t ciphertext;
	logic start_pulse;	// One cycle
	aes_block_t plaintext;	// Valid with done_pulse
	logic done_pulse;

	modport regs (output key, ciphertext, start_pulse, input plaintext, done_pulse);
	modport core (input key, ciphertext, start_pulse, output plaintext, done_pulse);

endinterface

`default_nettype wire

/* src/avalon_aes_regs.sv */
// Avalon-MM slave for the AES decryption peripheral
// Sixteen-word register map with byte-lane writes, read latency of one,
// start/done bookkeeping and the LED conduit
`timescale 1ns/1ps
`default_nettype none

module avalon_aes_regs
	import aes_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic avl_read,
	input  logic avl_write,
	input  logic avl_cs,
	input  logic [3:0] avl_byte_en,
	input  avl_addr_t avl_addr,
	input  aes_word_t avl_writedata,
	output aes_word_t avl_readdata,
	output aes_word_t export_data,
	aes_ctrl_if.regs ctrl
);

	aes_word_t regs_q [0:11];	// Key, encrypted and decrypted message
	logic start_q;
	logic done_q;
	logic wr_en;
	logic rd_en;
	logic start_wr;
	logic start_set;
	aes_word_t rd_word;

	assign wr_en = avl_cs && avl_write;
	assign rd_en = avl_cs && avl_read;
	assign start_wr = wr_en && (avl_addr == reg_start) && avl_byte_en[0];
	assign start_set = start_wr && avl_writedata[0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 12; i++)
				regs_q[i] <= '0;
			start_q <= 1'b0;
			done_q <= 1'b0;
			ctrl.start_pulse <= 1'b0;
		end else begin
			if (wr_en && (avl_addr < reg_unused0)) begin
				for (int b = 0; b < 4; b++)
					if (avl_byte_en[b])
						regs_q[avl_addr][8*b +: 8] <= avl_writedata[8*b +: 8];
			end
			if (ctrl.done_pulse) begin	// Result overrides a host write
				for (int i = 0; i < 4; i++)
					regs_q[reg_msg_de0 + i] <= ctrl.plaintext[127 - 32*i -: 32];
			end

			ctrl.start_pulse <= start_set && !start_q;	// Rising edge of start bit only

			if (ctrl.done_pulse)
				start_q <= 1'b0;
			else if (start_wr)
				start_q <= avl_writedata[0];

			if (ctrl.done_pulse)
				done_q <= 1'b1;
			else if (start_set)
				done_q <= 1'b0;	// New start clears done
			else if (wr_en && (avl_addr == reg_done) && avl_byte_en[0])
				done_q <= avl_writedata[0];
		end
	end

	always_comb begin
		if (avl_addr < reg_unused0)
			rd_word = regs_q[avl_addr];
		else if (avl_addr == reg_start)
			rd_word = {31'b0, start_q};
		else if (avl_addr == reg_done)
			rd_word = {31'b0, done_q};
		else
			rd_word = '0;	// Unused words
	end

	// Holds last value between reads
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			avl_readdata <= '0;
		else if (rd_en)
			avl_readdata <= rd_word;
	end

	assign ctrl.key = {regs_q[reg_key0], regs_q[reg_key0 + 1],
		regs_q[reg_key0 + 2], regs_q[reg_key0 + 3]};
	assign ctrl.ciphertext = {regs_q[reg_msg_en0], regs_q[reg_msg_en0 + 1],
		regs_q[reg_msg_en0 + 2], regs_q[reg_msg_en0 + 3]};

	// LEDs show the outer halves of the ciphertext
	assign export_data = {regs_q[reg_msg_en0][31:16], regs_q[reg_msg_en0 + 3][15:0]};

endmodule

`default_nettype wire

/* src/aes_key_expand.sv */
// Serial AES-128 key schedule
// Stores the cipher key as round key 0, then one new round key per cycle
`timescale 1ns/1ps
`default_nettype none

module aes_key_expand
	import aes_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  aes_block_t key,
	output round_key_array_t round_keys,
	output logic ready
);

	logic [3:0] idx;	// Next key to build
	logic busy;
	aes_block_t prev_key;
	aes_word_t w3_sub;
	aes_word_t temp;
	aes_block_t next_key;

	assign prev_key = round_keys[idx - 4'd1];

	always_comb begin
		// RotWord then SubWord on the last word
		w3_sub = {sbox(prev_key[23:16]), sbox(prev_key[15:8]),
			sbox(prev_key[7:0]), sbox(prev_key[31:24])};
		temp = w3_sub ^ {rcon(idx), 24'b0};
		next_key[127:96] = prev_key[127:96] ^ temp;
		next_key[95:64] = prev_key[95:64] ^ next_key[127:96];
		next_key[63:32] = prev_key[63:32] ^ next_key[95:64];
		next_key[31:0] = prev_key[31:0] ^ next_key[63:32];
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= 4'd0;
			busy <= 1'b0;
			ready <= 1'b0;
		end else if (load) begin
			idx <= 4'd1;
			busy <= 1'b1;
			ready <= 1'b0;
		end else if (busy) begin
			idx <= idx + 4'd1;
			if (idx == 4'd10) begin	// Last key written this cycle
				busy <= 1'b0;
				ready <= 1'b1;
			end
		end
	end

	// Key storage
	always_ff @(posedge clk) begin
		if (load)
			round_keys[0] <= key;
		else if (busy)
			round_keys[idx] <= next_key;
	end

endmodule

`default_nettype wire

/* src/aes_inv_round.sv */
// One AES inverse round, purely combinational
// InvShiftRows, InvSubBytes, AddRoundKey, then InvMixColumns unless last
`timescale 1ns/1ps
`default_nettype none

module aes_inv_round
	import aes_pkg::*;
(
	input  aes_block_t state_in,
	input  aes_block_t round_key,
	input  logic last,
	output aes_block_t state_out
);

	// Byte i sits at row i%4, column i/4
	logic [0:15][7:0] in_b;
	logic [0:15][7:0] key_b;
	logic [0:15][7:0] keyed_b;
	logic [0:15][7:0] mixed_b;

	// GF(2^8) product with a 4-bit constant
	function automatic logic [7:0] gmul(input logic [7:0] b, input logic [3:0] m);
		logic [7:0] x2;
		logic [7:0] x4;
		logic [7:0] x8;
		x2 = {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
		x4 = {x2[6:0], 1'b0} ^ (x2[7] ? 8'h1b : 8'h00);
		x8 = {x4[6:0], 1'b0} ^ (x4[7] ? 8'h1b : 8'h00);
		return (m[0] ? b : 8'h00) ^ (m[1] ? x2 : 8'h00) ^
			(m[2] ? x4 : 8'h00) ^ (m[3] ? x8 : 8'h00);
	endfunction

	assign in_b = state_in;
	assign key_b = round_key;

	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++)
				keyed_b[4*c + r] = inv_sbox(in_b[4*((c - r + 4) % 4) + r]) ^ key_b[4*c + r];
		end
		for (int c = 0; c < 4; c++) begin
			mixed_b[4*c] = gmul(keyed_b[4*c], 4'd14) ^ gmul(keyed_b[4*c + 1], 4'd11) ^
				gmul(keyed_b[4*c + 2], 4'd13) ^ gmul(keyed_b[4*c + 3], 4'd9);
			mixed_b[4*c + 1] = gmul(keyed_b[4*c], 4'd9) ^ gmul(keyed_b[4*c + 1], 4'd14) ^
				gmul(keyed_b[4*c + 2], 4'd11) ^ gmul(keyed_b[4*c + 3], 4'd13);
			mixed_b[4*c + 2] = gmul(keyed_b[4*c], 4'd13) ^ gmul(keyed_b[4*c + 1], 4'd9) ^
				gmul(keyed_b[4*c + 2], 4'd14) ^ gmul(keyed_b[4*c + 3], 4'd11);
			mixed_b[4*c + 3] = gmul(keyed_b[4*c], 4'd11) ^ gmul(keyed_b[4*c + 1], 4'd13) ^
				gmul(keyed_b[4*c + 2], 4'd9) ^ gmul(keyed_b[4*c + 3], 4'd14);
		end
	end

	assign state_out = last ? aes_block_t'(keyed_b) : aes_block_t'(mixed_b);	// No mix on final round

endmodule

`default_nettype wire

/* src/aes_decrypt_core.sv */
// Iterative AES-128 decryption core
// Expands the key, adds round key 10, then runs ten inverse rounds at one per
// cycle and returns the plaintext with a done pulse, 22 cycles after start
`timescale 1ns/1ps
`default_nettype none

module aes_decrypt_core
	import aes_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	aes_ctrl_if.core ctrl
);

	core_state_t state;
	logic [3:0] rnd;	// Expansion step, then round key index
	logic start_accept;
	aes_block_t blk_q;
	aes_block_t round_out;
	round_key_array_t round_keys;
	logic key_ready;

	assign start_accept = ctrl.start_pulse && (state == s_idle);	// Busy core ignores start

	aes_key_expand u_key_expand (
		.clk(clk),
		.rst_n(rst_n),
		.load(start_accept),
		.key(ctrl.key),
		.round_keys(round_keys),
		.ready(key_ready)
	);

	aes_inv_round u_inv_round (
		.state_in(blk_q),
		.round_key(round_keys[rnd]),
		.last(rnd == 4'd0),
		.state_out(round_out)
	);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= s_idle;
			rnd <= 4'd0;
		end else begin
			unique case (state)
				s_idle:
					if (start_accept) begin
						state <= s_expand;
						rnd <= 4'd0;
					end
				s_expand:	// Ten schedule steps after the load
					if (rnd == 4'd9)
						state <= s_first_key;
					else
						rnd <= rnd + 4'd1;
				s_first_key:
					if (key_ready) begin
						state <= s_rounds;
						rnd <= 4'd9;
					end
				s_rounds:
					if (rnd == 4'd0)
						state <= s_write_back;
					else
						rnd <= rnd - 4'd1;
				s_write_back:
					state <= s_idle;
				default:
					state <= s_idle;
			endcase
		end
	end

	// Working block, ciphertext latched only on an accepted start
	always_ff @(posedge clk) begin
		if (start_accept)
			blk_q <= ctrl.ciphertext;
		else if (state == s_first_key && key_ready)
			blk_q <= blk_q ^ round_keys[10];
		else if (state == s_rounds)
			blk_q <= round_out;
	end

	assign ctrl.plaintext = blk_q;
	assign ctrl.done_pulse = (state == s_write_back);

endmodule

`default_nettype wire

/* src/aes_periph_top.sv */
// AES-128 decryption peripheral top level
// Avalon-MM register block and iterative decryption core
`timescale 1ns/1ps
`default_nettype none

module aes_periph_top
	import aes_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic avl_read,
	input  logic avl_write,
	input  logic avl_cs,
	input  logic [3:0] avl_byte_en,
	input  avl_addr_t avl_addr,
	input  aes_word_t avl_writedata,
	output aes_word_t avl_readdata,
	output aes_word_t export_data	// LED conduit
);

	aes_ctrl_if ctrl_if ();

	avalon_aes_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.avl_read(avl_read),
		.avl_write(avl_write),
		.avl_cs(avl_cs),
		.avl_byte_en(avl_byte_en),
		.avl_addr(avl_addr),
		.avl_writedata(avl_writedata),
		.avl_readdata(avl_readdata),
		.export_data(export_data),
		.ctrl(ctrl_if.regs)
	);

	aes_decrypt_core u_core (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl_if.core)
	);

endmodule

`default_nettype wire

/* bench/aes_tb_ref.svh */
// Reference model for the AES peripheral testbench
// Register map rules, LED word and FIPS-197 vectors
`ifndef aes_tb_ref_svh
`define aes_tb_ref_svh

// Enabled byte lanes take the new data, the rest keep the old
function automatic aes_word_t merge_lanes(input aes_word_t old, input aes_word_t data,
	input logic [3:0] be);
	aes_word_t res;
	res = old;
	for (int b = 0; b < 4; b++)
		if (be[b])
			res[8*b +: 8] = data[8*b +: 8];
	return res;
endfunction

// Value a read returns for a stored word
function automatic aes_word_t reg_read_value(input avl_addr_t addr, input aes_word_t stored);
	aes_word_t res;
	if (addr == 4'd12 || addr == 4'd13)
		res = '0;	// Unused words
	else if (addr == 4'd14 || addr == 4'd15)
		res = {31'b0, stored[0]};	// Start and done
	else
		res = stored;
	return res;
endfunction

function automatic aes_word_t led_word(input aes_word_t reg4, input aes_word_t reg7);
	return {reg4[31:16], reg7[15:0]};
endfunction

// FIPS-197 C.1 first, Appendix B second
localparam aes_block_t vec_key [0:1] = '{128'h000102030405060708090a0b0c0d0e0f,
	128'h2b7e151628aed2a6abf7158809cf4f3c};
localparam aes_block_t vec_cipher [0:1] = '{128'h69c4e0d86a7b0430d8cdb78070b4c55a,
	128'h3925841d02dc09fbdc118597196a0b32};
localparam aes_block_t vec_plain [0:1] = '{128'h00112233445566778899aabbccddeeff,
	128'h3243f6a8885a308d313198a2e0370734};

`endif

/* bench/aes_tb.sv */
// Testbench for the AES-128 decryption peripheral
// Register map checks over Avalon-MM, then FIPS-197 decryptions
`timescale 1ns/1ps
`default_nettype none

module aes_tb
	import aes_pkg::*;
();

	`include "aes_tb_ref.svh"

	localparam int num_rand_writes = 48;
	localparam int num_tests = num_rand_writes + 2 + 32 + 3;	// Accesses, sweeps, runs
	localparam int max_polls = 40;

	logic clk;
	logic rst_n;
	logic avl_read;
	logic avl_write;
	logic avl_cs;
	logic [3:0] avl_byte_en;
	avl_addr_t avl_addr;
	aes_word_t avl_writedata;
	aes_word_t avl_readdata;
	aes_word_t export_data;

	aes_word_t shadow [0:15];	// Expected register contents
	int word_checks = 0;
	int block_checks = 0;
	int word_errors = 0;
	int block_errors = 0;
	int other_errors = 0;
	aes_word_t word_got_q[$];
	aes_word_t word_exp_q[$];
	string word_name_q[$];
	aes_block_t block_got_q[$];
	aes_block_t block_exp_q[$];
	string block_name_q[$];

	aes_periph_top dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.avl_read(avl_read),
		.avl_write(avl_write),
		.avl_cs(avl_cs),
		.avl_byte_en(avl_byte_en),
		.avl_addr(avl_addr),
		.avl_writedata(avl_writedata),
		.avl_readdata(avl_readdata),
		.export_data(export_data)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_word(input string name, input aes_word_t got, input aes_word_t exp);
		word_checks++;
		if (got !== exp) begin
			word_errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_block(input string name, input aes_block_t got, input aes_block_t exp);
		block_checks++;
		if (got !== exp) begin
			block_errors++;
			$display("ERROR %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic post_word(input string name, input aes_word_t got, input aes_word_t exp);
		word_name_q.push_back(name);
		word_got_q.push_back(got);
		word_exp_q.push_back(exp);
	endtask

	// One access per call on the falling edge
	task automatic bus_write(input avl_addr_t addr, input aes_word_t data, input logic [3:0] be);
		@(negedge clk);
		avl_cs = 1'b1;
		avl_write = 1'b1;
		avl_addr = addr;
		avl_writedata = data;
		avl_byte_en = be;
		@(negedge clk);
		avl_cs = 1'b0;
		avl_write = 1'b0;
	endtask

	task automatic bus_read(input avl_addr_t addr, output aes_word_t data);
		@(negedge clk);
		avl_cs = 1'b1;
		avl_read = 1'b1;
		avl_addr = addr;
		@(negedge clk);
		avl_cs = 1'b0;
		avl_read = 1'b0;
		data = avl_readdata;	// Latency of one
	endtask

	task automatic write_reg(input avl_addr_t addr, input aes_word_t data, input logic [3:0] be);
		bus_write(addr, data, be);
		if (addr < 4'd12)
			shadow[addr] = merge_lanes(shadow[addr], data, be);
		else if (addr == 4'd14 && be[0]) begin
			shadow[14] = {31'b0, data[0]};
			if (data[0])
				shadow[15] = '0;	// New start clears done
		end
	endtask

	task automatic read_check(input avl_addr_t addr);
		aes_word_t got;
		bus_read(addr, got);
		post_word($sformatf("avl_readdata[%0d]", addr), got, reg_read_value(addr, shadow[addr]));
	endtask

	task automatic check_leds();
		post_word("export_data", export_data, led_word(shadow[4], shadow[7]));
	endtask

	task automatic run_vector(input int v, input logic overwrite);
		aes_word_t got;
		aes_block_t pt_got;
		int polls;
		for (int i = 0; i < 4; i++)
			write_reg(avl_addr_t'(i), vec_key[v][127 - 32*i -: 32], 4'hf);
		for (int i = 0; i < 4; i++)
			write_reg(avl_addr_t'(4 + i), vec_cipher[v][127 - 32*i -: 32], 4'hf);
		check_leds();
		write_reg(4'd14, $urandom() | 32'h1, 4'hf);	// Upper bits must never show
		if (overwrite) begin
			for (int i = 0; i < 4; i++)
				write_reg(avl_addr_t'(i), $urandom(), 4'hf);
			write_reg(4'd14, 32'h1, 4'h1);	// Second start while busy
			for (int i = 0; i < 4; i++)
				write_reg(avl_addr_t'(4 + i), $urandom(), 4'hf);
			check_leds();
		end else
			read_check(4'd15);
		read_check(4'd14);
		polls = 0;
		got = '0;
		while (!got[0] && polls < max_polls) begin
			bus_read(4'd15, got);
			post_word("avl_readdata[15] upper bits", got & 32'hffff_fffe, '0);
			polls++;
		end
		if (!got[0]) begin
			other_errors++;
			$display("Done bit never came up for vector %0d after %0d polls", v, polls);
		end
		for (int i = 0; i < 4; i++)
			shadow[8 + i] = vec_plain[v][127 - 32*i -: 32];
		shadow[14] = '0;	// Finished run drops start and sets done
		shadow[15] = 32'h1;
		for (int i = 0; i < 4; i++) begin
			bus_read(avl_addr_t'(8 + i), got);
			pt_got[127 - 32*i -: 32] = got;
		end
		block_name_q.push_back($sformatf("plaintext of vector %0d", v));
		block_got_q.push_back(pt_got);
		block_exp_q.push_back(vec_plain[v]);
		read_check(4'd14);
		read_check(4'd15);
	endtask

	initial begin : compare
		forever begin
			@(posedge clk);
			while (word_got_q.size() > 0)
				check_word(word_name_q.pop_front(), word_got_q.pop_front(),
					word_exp_q.pop_front());
			while (block_got_q.size() > 0)
				check_block(block_name_q.pop_front(), block_got_q.pop_front(),
					block_exp_q.pop_front());
		end
	end

	initial begin : watchdog
		repeat (num_tests * 40 + 2000) @(posedge clk);
		$display("Timeout after %0d cycles, the tests did not finish", num_tests * 40 + 2000);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : stimulus
		avl_addr_t addr;
		void'($urandom(32'h2fe1));
		rst_n = 1'b0;
		avl_read = 1'b0;
		avl_write = 1'b0;
		avl_cs = 1'b0;
		avl_byte_en = '0;
		avl_addr = '0;
		avl_writedata = '0;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int a = 0; a < 16; a++)
			read_check(avl_addr_t'(a));
		check_leds();
		for (int n = 0; n < num_rand_writes; n++) begin
			addr = avl_addr_t'($urandom_range(7, 0));
			write_reg(addr, $urandom(), 4'($urandom()));
			read_check(addr);
			check_leds();
		end
		write_reg(4'd12, $urandom(), 4'hf);
		write_reg(4'd13, $urandom(), 4'hf);
		read_check(4'd12);
		read_check(4'd13);
		run_vector(0, 1'b0);
		run_vector(1, 1'b0);	// Start here clears the done bit of vector 0
		run_vector(1, 1'b1);
		for (int a = 0; a < 16; a++)
			read_check(avl_addr_t'(a));
		check_leds();
		repeat (2) @(posedge clk);
		@(negedge clk);
		$display("Checks: %0d words, %0d blocks; errors: %0d word, %0d block, %0d other",
			word_checks, block_checks, word_errors, block_errors, other_errors);
		if (word_errors + block_errors + other_errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
src/aes_pkg.sv
src/aes_ctrl_if.sv
src/avalon_aes_regs.sv
src/aes_key_expand.sv
src/aes_inv_round.sv
src/aes_decrypt_core.sv
src/aes_periph_top.sv
bench/aes_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = aes_tb
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@! grep -q "SIMULATION FAILED" $(LOG) && grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
